// File: bench/scalar_core_tb.sv
`default_nettype none

module scalar_core_tb;
	import scalar_cfg_pkg::*;
	import scalar_isa_pkg::*;

	localparam int      IMEM_ADDR_W = 6;
	localparam wb_adr_t CTRL_ADR    = 8'h80;
	localparam wb_adr_t REG_ADR     = 8'h88;

	// Executed instructions over all tests, and bus accesses over all tests
	localparam int INSTR_TOTAL    = 8 + 9 + 7 + 4 + 2 * 19;
	localparam int BUS_OPS        = 142;
	localparam int TIMEOUT_CYCLES = 2 * INSTR_TOTAL + 3 * BUS_OPS + 100;
	localparam int DONE_LIMIT     = 200;

	logic    clock = 1'b0;
	logic    reset;
	wb_req_t wb_req;
	logic    wb_ack;
	data_t   wb_dat_r;
	status_t status;

	int    cycle = 0;
	int    start_cycle;
	data_t prog [$];                // Program image, word i at address i
	data_t exp_regs [NUM_REGS];     // Expected register contents
	logic  exp_zero;

	scalar_core #(.IMEM_ADDR_W(IMEM_ADDR_W)) uut (
		.clock(clock), .reset(reset),
		.wb_req(wb_req), .wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
		.status(status)
	);

	always #20 clock = ~clock;

	// Watchdog for the whole run
	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
		end
	end

	//////////////////////////////
	// Reporting

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_equal(input string name, input data_t expected, input data_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("Error: %s expected 0x%04h actual 0x%04h",
				name, expected, actual));
		end
	endtask

	//////////////////////////////
	// Wishbone host

	task automatic wb_access(input logic we, input wb_adr_t adr, input data_t data_w,
		output data_t data_r);
		int waited;
		@(negedge clock);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: data_w};
		waited = 0;
		do begin
			@(negedge clock);
			waited++;
		end while (!wb_ack && waited < 4);
		if (!wb_ack) begin
			abort_run($sformatf("No acknowledge for bus address 0x%02h", adr));
		end
		data_r = wb_dat_r;
		wb_req = '0;                 // Drop stb, ack falls next edge
	endtask

	task automatic wb_write(input wb_adr_t adr, input data_t data);
		data_t unused;
		wb_access(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input wb_adr_t adr, output data_t data);
		wb_access(1'b0, adr, '0, data);
	endtask

	//////////////////////////////
	// Instruction words and model

	function automatic data_t enc_alu(input opcode_t op, input reg_idx_t dst, src1, src2);
		return {op, dst, src1, src2, 3'b000};
	endfunction

	function automatic data_t enc_imm(input reg_idx_t dst, input logic [7:0] value);
		return {OP_LDI, dst, 1'b0, value};
	endfunction

	function automatic data_t enc_jmp(input opcode_t op, input logic [11:0] target);
		return {op, target};
	endfunction

	// Expected effect of one register write
	task automatic model_write(input reg_idx_t idx, input data_t value);
		exp_regs[idx] = value;
		exp_zero = (value == 16'h0000);
	endtask

	task automatic load_program();
		foreach (prog[i]) begin
			wb_write(wb_adr_t'(i), prog[i]);
		end
	endtask

	task automatic start_program();
		wb_write(CTRL_ADR, 16'h0001);
		start_cycle = cycle;         // Cycle of the start ack
	endtask

	task automatic wait_done(output int cycles);
		do begin
			@(negedge clock);
			if (cycle - start_cycle > DONE_LIMIT) begin
				abort_run("Program never reached its halt instruction");
			end
		end while (!status.done);
		cycles = cycle - start_cycle;
	endtask

	task automatic run_program(output int cycles);
		start_program();
		wait_done(cycles);
	endtask

	task automatic check_regs(input string name);
		data_t value;
		for (int i = 0; i < NUM_REGS; i++) begin
			wb_read(wb_adr_t'(REG_ADR + i), value);
			check_equal($sformatf("%s r%0d", name, i), exp_regs[i], value);
		end
	endtask

	// Bus read and status port, both in the ack cycle
	task automatic check_status(input string name, input logic busy, input logic done);
		data_t value;
		data_t expected;
		expected = {13'd0, busy, done, exp_zero};
		wb_read(CTRL_ADR, value);
		check_equal({name, " status"}, expected, value);
		check_equal({name, " status port"}, expected, data_t'(status));
	endtask

	//////////////////////////////
	// Directed tests

	task automatic test_reset_state();
		check_status("reset", 1'b0, 1'b0);
		check_regs("reset");
	endtask

	task automatic test_arith_logic();
		logic [7:0] a;
		logic [7:0] b;
		data_t      ra;
		data_t      rb;
		int         cycles;
		a = {1'b0, 7'($urandom())};
		b = {1'b1, 7'($urandom())};  // b above a, so SUB wraps
		ra = {8'h00, a};
		rb = {8'h00, b};
		prog.delete();
		prog.push_back(enc_imm(3'd0, a));
		prog.push_back(enc_imm(3'd1, b));
		prog.push_back(enc_alu(OP_ADD, 3'd2, 3'd0, 3'd1));
		prog.push_back(enc_alu(OP_SUB, 3'd3, 3'd0, 3'd1));
		prog.push_back(enc_alu(OP_AND, 3'd4, 3'd0, 3'd1));
		prog.push_back(enc_alu(OP_OR, 3'd5, 3'd0, 3'd1));
		prog.push_back(enc_alu(OP_XOR, 3'd6, 3'd0, 3'd1));
		prog.push_back(enc_jmp(OP_HALT, 12'h000));
		load_program();
		run_program(cycles);
		model_write(3'd0, ra);
		model_write(3'd1, rb);
		model_write(3'd2, ra + rb);
		model_write(3'd3, ra - rb);
		model_write(3'd4, ra & rb);
		model_write(3'd5, ra | rb);
		model_write(3'd6, ra ^ rb);
		check_equal("arith cycles", data_t'(2 * 8 + 1), data_t'(cycles));
		check_regs("arith");
		check_status("arith", 1'b0, 1'b1);
	endtask

	task automatic test_zero_branch();
		int cycles;
		prog.delete();
		prog.push_back(enc_imm(3'd0, 8'h21));
		prog.push_back(enc_imm(3'd1, 8'h21));
		prog.push_back(enc_alu(OP_SUB, 3'd2, 3'd0, 3'd1));   // Zero result
		prog.push_back(enc_jmp(OP_BRZ, 12'd5));
		prog.push_back(enc_imm(3'd3, 8'hEE));                // Skipped
		prog.push_back(enc_imm(3'd4, 8'h05));
		prog.push_back(enc_jmp(OP_BRZ, 12'd8));              // Not taken
		prog.push_back(enc_imm(3'd5, 8'h07));
		prog.push_back(enc_alu(OP_SUB, 3'd7, 3'd4, 3'd4));
		prog.push_back(enc_jmp(OP_HALT, 12'h000));
		load_program();
		run_program(cycles);
		model_write(3'd0, 16'h0021);
		model_write(3'd1, 16'h0021);
		model_write(3'd2, 16'h0000);
		model_write(3'd4, 16'h0005);
		model_write(3'd5, 16'h0007);
		model_write(3'd7, 16'h0000);
		check_equal("branch cycles", data_t'(2 * 9 + 1), data_t'(cycles));
		check_regs("branch");
		check_status("branch", 1'b0, 1'b1);
	endtask

	// Runs right after the branch test, which leaves the zero flag set
	task automatic test_straight_timing();
		int         lengths [2] = '{1, 6};
		int         cycles;
		logic [7:0] value;
		foreach (lengths[k]) begin
			prog.delete();
			exp_zero = 1'b0;             // Cleared by start
			for (int i = 0; i < lengths[k] - 1; i++) begin
				value = 8'($urandom());
				prog.push_back(enc_imm(3'd7, value));
				model_write(3'd7, {8'h00, value});
			end
			prog.push_back(enc_jmp(OP_HALT, 12'h000));
			load_program();
			run_program(cycles);
			check_equal($sformatf("timing n=%0d cycles", lengths[k]),
				data_t'(2 * lengths[k] + 1), data_t'(cycles));
			check_regs("timing");
			check_status("timing", 1'b0, 1'b1);
		end
	endtask

	task automatic test_jump();
		int          cycles;
		logic [11:0] far_target;
		far_target = (12'hFFF << IMEM_ADDR_W) | 12'd5;   // High bits beyond memory
		prog.delete();
		prog.push_back(enc_imm(3'd0, 8'h3C));
		prog.push_back(enc_jmp(OP_JMP, far_target));
		prog.push_back(enc_imm(3'd1, 8'hAA));
		prog.push_back(enc_imm(3'd2, 8'hBB));
		prog.push_back(enc_imm(3'd3, 8'hCC));
		prog.push_back(enc_imm(3'd4, 8'h44));
		prog.push_back(enc_jmp(OP_HALT, 12'h000));
		load_program();
		run_program(cycles);
		model_write(3'd0, 16'h003C);
		model_write(3'd4, 16'h0044);
		check_equal("jump cycles", data_t'(2 * 4 + 1), data_t'(cycles));
		check_regs("jump");
		check_status("jump", 1'b0, 1'b1);
	endtask

	task automatic test_busy_protection();
		int cycles;
		prog.delete();
		prog.push_back(enc_imm(3'd0, 8'h01));
		prog.push_back(enc_imm(3'd1, 8'h03));
		repeat (16) prog.push_back(enc_alu(OP_ADD, 3'd1, 3'd1, 3'd0));
		prog.push_back(enc_jmp(OP_HALT, 12'h000));
		load_program();
		model_write(3'd0, 16'h0001);
		model_write(3'd1, 16'h0013);
		start_program();
		wb_write(8'h11, enc_imm(3'd2, 8'h99));   // Would replace the last ADD
		wb_write(CTRL_ADR, 16'h0001);
		check_status("busy run", 1'b1, 1'b0);
		wait_done(cycles);
		check_equal("busy run cycles", data_t'(2 * 19 + 1), data_t'(cycles));
		check_regs("busy run");
		check_status("busy run", 1'b0, 1'b1);

		wb_write(8'h89, 16'hDEAD);               // Register page is read only
		check_regs("register write");

		run_program(cycles);
		check_equal("rerun cycles", data_t'(2 * 19 + 1), data_t'(cycles));
		check_regs("rerun");
		check_status("rerun", 1'b0, 1'b1);
	endtask

	//////////////////////////////
	// Main sequence
	initial begin
		void'($urandom(48125));
		wb_req = '0;
		reset = 1'b1;
		exp_zero = 1'b0;
		for (int i = 0; i < NUM_REGS; i++) begin
			exp_regs[i] = '0;
		end
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		test_reset_state();
		test_arith_logic();
		test_zero_branch();
		test_straight_timing();
		test_jump();
		test_busy_protection();

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: design/instr_mem.sv
`default_nettype none

module instr_mem #(
	parameter int IMEM_ADDR_W = 6
) (
	input  logic                   clock,
	input  logic                   we,
	input  logic [IMEM_ADDR_W-1:0] waddr,
	input  scalar_cfg_pkg::data_t  wdata,
	input  logic                   fetch_en,
	input  logic [IMEM_ADDR_W-1:0] raddr,
	output scalar_isa_pkg::instr_t instr
);
	import scalar_cfg_pkg::*;

	localparam int DEPTH = 2 ** IMEM_ADDR_W;

	data_t mem [DEPTH];

	// Host stores, fetch reads on its own port
	always_ff @(posedge clock) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		if (fetch_en) begin
			instr <= mem[raddr];    // Valid during execute
		end
	end

endmodule

`default_nettype wire

// File: design/program_counter.sv
`default_nettype none

module program_counter #(
	parameter int IMEM_ADDR_W = 6
) (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   pc_clear,
	input  logic                   pc_step,
	input  logic                   pc_load,
	input  logic [IMEM_ADDR_W-1:0] target,
	output logic [IMEM_ADDR_W-1:0] pc
);

	// Clear wins over load, load over step
	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= '0;
		end else if (pc_clear) begin
			pc <= '0;
		end else if (pc_load) begin
			pc <= target;
		end else if (pc_step) begin
			pc <= pc + 1'b1;        // Wraps at the top of memory
		end
	end

endmodule

`default_nettype wire

// File: design/reg_file.sv
`default_nettype none

module reg_file (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     we,
	input  scalar_cfg_pkg::reg_idx_t widx,
	input  scalar_cfg_pkg::data_t    wdata,
	input  scalar_cfg_pkg::reg_idx_t ridx_a,
	input  scalar_cfg_pkg::reg_idx_t ridx_b,
	input  scalar_cfg_pkg::reg_idx_t ridx_host,
	output scalar_cfg_pkg::data_t    rdata_a,
	output scalar_cfg_pkg::data_t    rdata_b,
	output scalar_cfg_pkg::data_t    rdata_host
);
	import scalar_cfg_pkg::*;

	data_t regs [NUM_REGS];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[widx] <= wdata;
		end
	end

	// Operand ports and host port
	assign rdata_a    = regs[ridx_a];
	assign rdata_b    = regs[ridx_b];
	assign rdata_host = regs[ridx_host];

endmodule

`default_nettype wire

// File: design/scalar_alu.sv
`default_nettype none

module scalar_alu (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     start,
	input  logic                     exec_en,
	input  scalar_isa_pkg::instr_t   instr,
	input  scalar_cfg_pkg::data_t    src_a,
	input  scalar_cfg_pkg::data_t    src_b,
	output scalar_cfg_pkg::reg_idx_t ridx_a,
	output scalar_cfg_pkg::reg_idx_t ridx_b,
	output logic                     wb_we,
	output scalar_cfg_pkg::reg_idx_t wb_idx,
	output scalar_cfg_pkg::data_t    wb_data,
	output logic                     zero
);
	import scalar_cfg_pkg::*;
	import scalar_isa_pkg::*;

	data_t result;
	logic  writes_reg;

	// Operand addresses from the alu view
	assign ridx_a = instr.alu.src1;
	assign ridx_b = instr.alu.src2;

	//////////////////////////////
	// Execute
	always_comb begin
		result     = '0;
		writes_reg = 1'b1;
		case (instr.alu.op)
			OP_ADD:  result = src_a + src_b;
			OP_SUB:  result = src_a - src_b;    // Modulo 2**16
			OP_AND:  result = src_a & src_b;
			OP_OR:   result = src_a | src_b;
			OP_XOR:  result = src_a ^ src_b;
			OP_LDI:  result = data_t'(instr.imm.value);
			default: writes_reg = 1'b0;         // Jumps, halt, unused codes
		endcase
	end

	// Write-back on the edge that ends execute
	assign wb_we   = exec_en & writes_reg;
	assign wb_idx  = instr.alu.dst;
	assign wb_data = result;

	// Zero flag follows the last write
	always_ff @(posedge clock) begin
		if (reset) begin
			zero <= 1'b0;
		end else if (start) begin
			zero <= 1'b0;
		end else if (wb_we) begin
			zero <= (result == '0);
		end
	end

endmodule

`default_nettype wire

// File: design/scalar_cfg_pkg.sv
`default_nettype none

package scalar_cfg_pkg;

	//////////////////////////////
	// Data path sizes
	localparam int DATA_W    = 16;
	localparam int NUM_REGS  = 8;
	localparam int REG_IDX_W = $clog2(NUM_REGS);

	typedef logic [DATA_W-1:0]    data_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	//////////////////////////////
	// Host bus
	typedef logic [7:0] wb_adr_t;      // Word address

	typedef struct packed {
		logic    cyc;
		logic    stb;
		logic    we;
		wb_adr_t adr;
		data_t   dat_w;
	} wb_req_t;

	// Zero-extended on a bus read
	typedef struct packed {
		logic busy;
		logic done;
		logic zero;                    // Last written value was zero
	} status_t;

endpackage

`default_nettype wire

// File: design/scalar_core.sv
`default_nettype none

module scalar_core #(
	parameter int IMEM_ADDR_W = 6
) (
	input  logic                    clock,
	input  logic                    reset,
	input  scalar_cfg_pkg::wb_req_t wb_req,
	output logic                    wb_ack,
	output scalar_cfg_pkg::data_t   wb_dat_r,
	output scalar_cfg_pkg::status_t status
);
	import scalar_cfg_pkg::*;
	import scalar_isa_pkg::*;

	reg_idx_t               host_reg_idx;
	data_t                  host_reg_data;
	logic                   imem_we;
	logic [IMEM_ADDR_W-1:0] imem_addr;
	data_t                  imem_data;
	logic                   start;

	logic                   pc_clear;
	logic                   pc_step;
	logic                   pc_load;
	logic                   fetch_en;
	logic                   exec_en;
	logic                   busy;
	logic                   done;
	logic                   zero;
	logic [IMEM_ADDR_W-1:0] pc;
	logic [IMEM_ADDR_W-1:0] pc_target;
	instr_t                 instr;

	reg_idx_t ridx_a;
	reg_idx_t ridx_b;
	data_t    src_a;
	data_t    src_b;
	logic     wb_we;
	reg_idx_t wb_idx;
	data_t    wb_data;

	assign status    = '{busy: busy, done: done, zero: zero};
	assign pc_target = instr.jmp.target[IMEM_ADDR_W-1:0];   // Low bits only

	//////////////////////////////
	// Control side
	wb_host_port #(.IMEM_ADDR_W(IMEM_ADDR_W)) u_host (
		.clock(clock), .reset(reset),
		.wb_req(wb_req), .wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
		.status(status),
		.host_reg_idx(host_reg_idx), .host_reg_data(host_reg_data),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
		.start(start)
	);

	sequencer_fsm u_seq (
		.clock(clock), .reset(reset), .start(start),
		.instr(instr), .zero(zero),
		.pc_clear(pc_clear), .pc_step(pc_step), .pc_load(pc_load),
		.fetch_en(fetch_en), .exec_en(exec_en),
		.busy(busy), .done(done)
	);

	program_counter #(.IMEM_ADDR_W(IMEM_ADDR_W)) u_pc (
		.clock(clock), .reset(reset),
		.pc_clear(pc_clear), .pc_step(pc_step), .pc_load(pc_load),
		.target(pc_target), .pc(pc)
	);

	//////////////////////////////
	// Data side
	instr_mem #(.IMEM_ADDR_W(IMEM_ADDR_W)) u_imem (
		.clock(clock),
		.we(imem_we), .waddr(imem_addr), .wdata(imem_data),
		.fetch_en(fetch_en), .raddr(pc), .instr(instr)
	);

	reg_file u_rf (
		.clock(clock), .reset(reset),
		.we(wb_we), .widx(wb_idx), .wdata(wb_data),
		.ridx_a(ridx_a), .ridx_b(ridx_b), .ridx_host(host_reg_idx),
		.rdata_a(src_a), .rdata_b(src_b), .rdata_host(host_reg_data)
	);

	scalar_alu u_alu (
		.clock(clock), .reset(reset), .start(start), .exec_en(exec_en),
		.instr(instr), .src_a(src_a), .src_b(src_b),
		.ridx_a(ridx_a), .ridx_b(ridx_b),
		.wb_we(wb_we), .wb_idx(wb_idx), .wb_data(wb_data),
		.zero(zero)
	);

endmodule

`default_nettype wire

// File: design/scalar_isa_pkg.sv
`default_nettype none

package scalar_isa_pkg;

	// Unlisted codes run as no-operations
	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_AND  = 4'd2,
		OP_OR   = 4'd3,
		OP_XOR  = 4'd4,
		OP_LDI  = 4'd5,
		OP_JMP  = 4'd6,
		OP_BRZ  = 4'd7,
		OP_HALT = 4'd15
	} opcode_t;

	//////////////////////////////
	// Instruction formats

	// Register to register
	typedef struct packed {
		opcode_t                  op;
		scalar_cfg_pkg::reg_idx_t dst;
		scalar_cfg_pkg::reg_idx_t src1;
		scalar_cfg_pkg::reg_idx_t src2;
		logic [2:0]               pad;
	} fmt_alu_t;

	// Immediate load
	typedef struct packed {
		opcode_t                  op;
		scalar_cfg_pkg::reg_idx_t dst;
		logic                     pad;
		logic [7:0]               value;
	} fmt_imm_t;

	// Jump and branch
	typedef struct packed {
		opcode_t    op;
		logic [11:0] target;
	} fmt_jmp_t;

	// One fetched word, three ways to read it
	typedef union packed {
		fmt_alu_t alu;
		fmt_imm_t imm;
		fmt_jmp_t jmp;
	} instr_t;

endpackage

`default_nettype wire

// File: design/sequencer_fsm.sv
`default_nettype none

module sequencer_fsm (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   start,
	input  scalar_isa_pkg::instr_t instr,
	input  logic                   zero,
	output logic                   pc_clear,
	output logic                   pc_step,
	output logic                   pc_load,
	output logic                   fetch_en,
	output logic                   exec_en,
	output logic                   busy,
	output logic                   done
);
	import scalar_isa_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_FETCH,
		S_EXEC,
		S_HALT
	} state_t;

	state_t state;
	state_t state_next;
	logic   is_halt;
	logic   take_jump;

	// Opcode decode on the jump view
	assign is_halt   = (instr.jmp.op == OP_HALT);
	assign take_jump = (instr.jmp.op == OP_JMP) | ((instr.jmp.op == OP_BRZ) & zero);

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE, S_HALT: begin
				if (start) begin
					state_next = S_FETCH;
				end
			end
			S_FETCH: state_next = S_EXEC;
			S_EXEC:  state_next = is_halt ? S_HALT : S_FETCH;
			default: state_next = S_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			state <= state_next;
		end
	end

	//////////////////////////////
	// Controls
	assign fetch_en = (state == S_FETCH);
	assign exec_en  = (state == S_EXEC);
	assign pc_clear = start & ((state == S_IDLE) | (state == S_HALT));
	assign pc_load  = exec_en & take_jump;
	assign pc_step  = exec_en & ~take_jump;     // Includes the halt itself
	assign busy     = fetch_en | exec_en;
	assign done     = (state == S_HALT);

endmodule

`default_nettype wire

// File: design/wb_host_port.sv
`default_nettype none

module wb_host_port #(
	parameter int IMEM_ADDR_W = 6
) (
	input  logic                     clock,
	input  logic                     reset,
	input  scalar_cfg_pkg::wb_req_t  wb_req,
	output logic                     wb_ack,
	output scalar_cfg_pkg::data_t    wb_dat_r,
	input  scalar_cfg_pkg::status_t  status,
	output scalar_cfg_pkg::reg_idx_t host_reg_idx,
	input  scalar_cfg_pkg::data_t    host_reg_data,
	output logic                     imem_we,
	output logic [IMEM_ADDR_W-1:0]   imem_addr,
	output scalar_cfg_pkg::data_t    imem_data,
	output logic                     start
);
	import scalar_cfg_pkg::*;

	localparam wb_adr_t    CTRL_ADR = 8'h80;
	localparam logic [4:0] REG_PAGE = 5'b10001;    // 0x88 to 0x8F

	logic    req_valid;
	logic    req_new;
	logic    ack_hold;       // Waiting for stb to drop
	wb_adr_t adr_q;

	assign req_valid = wb_req.cyc & wb_req.stb;
	assign req_new   = req_valid & ~wb_ack & ~ack_hold;

	//////////////////////////////
	// Handshake and write strobes
	always_ff @(posedge clock) begin
		if (reset) begin
			wb_ack   <= 1'b0;
			ack_hold <= 1'b0;
			imem_we  <= 1'b0;
			start    <= 1'b0;
		end else begin
			wb_ack  <= req_new;
			imem_we <= req_new & wb_req.we & ~wb_req.adr[7] & ~status.busy;
			start   <= req_new & wb_req.we & (wb_req.adr == CTRL_ADR)
				& wb_req.dat_w[0] & ~status.busy;
			if (!req_valid) begin
				ack_hold <= 1'b0;
			end else if (wb_ack) begin
				ack_hold <= 1'b1;
			end
		end
	end

	// Captured request, used in the ack cycle
	always_ff @(posedge clock) begin
		if (req_new) begin
			adr_q     <= wb_req.adr;
			imem_data <= wb_req.dat_w;
		end
	end

	assign imem_addr    = adr_q[IMEM_ADDR_W-1:0];
	assign host_reg_idx = adr_q[2:0];

	//////////////////////////////
	// Read data
	always_comb begin
		wb_dat_r = '0;
		if (wb_ack) begin
			if (adr_q == CTRL_ADR) begin
				wb_dat_r = data_t'(status);
			end else if (adr_q[7:3] == REG_PAGE) begin
				wb_dat_r = host_reg_data;
			end
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module scalar_core_tb -f sim.f -o scalar_core_sim

# The simulation status is not trusted, the log decides
./obj_dir/scalar_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test passed$" sim.log; then
	echo "run_sim: simulation result is PASS"
	exit 0
fi
echo "run_sim: simulation result is FAIL"
exit 1

// File: sim.f
design/scalar_cfg_pkg.sv
design/scalar_isa_pkg.sv
design/wb_host_port.sv
design/sequencer_fsm.sv
design/program_counter.sv
design/instr_mem.sv
design/reg_file.sv
design/scalar_alu.sv
design/scalar_core.sv
bench/scalar_core_tb.sv
